/* include/command_defs.svh */
`ifndef COMMAND_DEFS_SVH
`define COMMAND_DEFS_SVH

// number of compute units feeding the command path
`define NUM_CU 4

// entries per unit command fifo
`define CMD_FIFO_DEPTH 4

// largest single command in bytes
`define CACHELINE_BYTES 128

// opcode encodings
`define CMD_OP_READ  1'b0
`define CMD_OP_WRITE 1'b1

`endif

/* verilog/command_pkg.sv */
`default_nettype none

package command_pkg;

  ////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////

  typedef logic [1:0]  cu_id_t;     // compute unit index
  typedef logic [63:0] address_t;   // byte address
  typedef logic [11:0] xfer_size_t; // bytes per command
  typedef logic [19:0] job_len_t;   // bytes per job
  typedef logic        cmd_op_t;    // read or write

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////

  // one job handed to a compute unit
  typedef struct packed {
    address_t base;
    job_len_t length;
    cmd_op_t  op;
  } job_desc;

  // one cacheline command, 80 bits
  typedef struct packed {
    logic       valid;
    cu_id_t     cu_id;
    cmd_op_t    op;
    address_t   address;
    xfer_size_t size;
  } command_line;

  ////////////////////////////////////////
  // state machines
  ////////////////////////////////////////

  typedef enum logic {
    GEN_IDLE,
    GEN_RUN
  } gen_state_t;

  typedef enum logic [1:0] {
    ISS_EMPTY,
    ISS_REQ,
    ISS_ACKED
  } issue_state_t;

endpackage

`default_nettype wire

/* verilog/cu_command_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "command_defs.svh"

module cu_command_gen #(
  parameter command_pkg::cu_id_t UNIT_ID = '0
) (
  input  logic                  clock,
  input  logic                  rstn,
  input  logic                  start,
  input  command_pkg::job_desc  job,
  input  logic                  full,
  output logic                  push,
  output command_pkg::command_line cmd,
  output logic                  busy
);

  command_pkg::gen_state_t state;
  command_pkg::address_t   next_addr;  // address of the next line
  command_pkg::job_len_t   remaining;  // bytes not yet queued
  command_pkg::cmd_op_t    op_q;
  logic                    last_line;

  ////////////////////////////////////////
  // command for the current line
  ////////////////////////////////////////

  assign last_line = (remaining <= command_pkg::job_len_t'(`CACHELINE_BYTES));

  always_comb begin
    cmd.valid   = (state == command_pkg::GEN_RUN);
    cmd.cu_id   = UNIT_ID;
    cmd.op      = op_q;
    cmd.address = next_addr;
    // tail of the job may be shorter than a cacheline
    if (last_line) begin
      cmd.size = command_pkg::xfer_size_t'(remaining);
    end else begin
      cmd.size = command_pkg::xfer_size_t'(`CACHELINE_BYTES);
    end
  end

  assign push = (state == command_pkg::GEN_RUN) && !full;
  assign busy = (state == command_pkg::GEN_RUN);

  ////////////////////////////////////////
  // job state machine
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state <= command_pkg::GEN_IDLE;
    end else begin
      case (state)
        command_pkg::GEN_IDLE: begin
          if (start && (job.length != '0)) begin  // empty job never runs
            state <= command_pkg::GEN_RUN;
          end
        end
        command_pkg::GEN_RUN: begin
          if (push && last_line) begin
            state <= command_pkg::GEN_IDLE;
          end
        end
        default: state <= command_pkg::GEN_IDLE;
      endcase
    end
  end

  // address and byte counters
  always_ff @(posedge clock) begin
    if ((state == command_pkg::GEN_IDLE) && start) begin
      next_addr <= job.base;
      remaining <= job.length;
      op_q      <= job.op;
    end else if (push) begin
      next_addr <= next_addr + command_pkg::address_t'(`CACHELINE_BYTES);
      remaining <= remaining - command_pkg::job_len_t'(cmd.size);
    end
  end

  // a pushed line always carries bytes
  push_not_empty: assert property (
    @(posedge clock) disable iff (!rstn) push |-> (cmd.size != '0)
  );

endmodule

`default_nettype wire

/* verilog/command_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "command_defs.svh"

module command_fifo #(
  parameter int DEPTH = `CMD_FIFO_DEPTH
) (
  input  logic                     clock,
  input  logic                     rstn,
  input  logic                     push,
  input  command_pkg::command_line push_data,
  input  logic                     pop,
  output command_pkg::command_line head,
  output logic                     full,
  output logic                     empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  command_pkg::command_line mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // entries held
  logic             wr_en;
  logic             rd_en;

  // wrap at DEPTH so any depth works
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);
  assign wr_en = push && !full;
  assign rd_en = pop && !empty;

  // oldest entry shows without a pop
  assign head = mem[rd_ptr];

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_data;
    end
  end

  ////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none or both
      endcase
    end
  end

  // producer must respect full
  no_push_when_full: assert property (
    @(posedge clock) disable iff (!rstn) full |-> !push
  );

  // arbiter must only pop a requesting fifo
  no_pop_when_empty: assert property (
    @(posedge clock) disable iff (!rstn) empty |-> !pop
  );

endmodule

`default_nettype wire

/* verilog/command_buffer_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "command_defs.svh"

module command_buffer_arbiter #(
  parameter int NUM_REQUESTS = `NUM_CU
) (
  input  logic                                        clock,
  input  logic                                        rstn,
  input  logic                                        enabled,
  input  logic                                        issuer_ready,
  input  command_pkg::command_line [NUM_REQUESTS-1:0] command_buffer_in,
  input  logic [NUM_REQUESTS-1:0]                     requests,
  output command_pkg::command_line                    command_arbiter_out,
  output logic [NUM_REQUESTS-1:0]                     ready
);

  logic [NUM_REQUESTS-1:0]  grant;
  command_pkg::command_line winner;
  command_pkg::command_line line_q;   // registered payload
  logic                     valid_q;

  ////////////////////////////////////////
  // fixed priority, index 0 first
  ////////////////////////////////////////

  // isolate the lowest set request bit
  assign grant = requests & (~requests + NUM_REQUESTS'(1));

  // pop only when the issuer can take the line
  assign ready = grant & {NUM_REQUESTS{enabled && issuer_ready}};

  always_comb begin
    winner = '0;  // invalid line when nothing wins
    for (int i = 0; i < NUM_REQUESTS; i++) begin
      if (ready[i]) begin
        winner = command_buffer_in[i];
      end
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= |ready;
    end
  end

  always_ff @(posedge clock) begin
    line_q <= winner;
  end

  always_comb begin
    command_arbiter_out       = line_q;
    command_arbiter_out.valid = valid_q;
  end

  // at most one fifo popped per cycle
  ready_onehot: assert property (
    @(posedge clock) disable iff (!rstn) $onehot0(ready)
  );

endmodule

`default_nettype wire

/* verilog/command_issuer.sv */
`timescale 1ns/1ns
`default_nettype none

module command_issuer (
  input  logic                     clock,
  input  logic                     rstn,
  input  command_pkg::command_line cmd_in,
  output logic                     issuer_ready,
  output logic                     cmd_req,
  input  logic                     cmd_ack,
  output command_pkg::command_line cmd_out
);

  command_pkg::issue_state_t state;
  command_pkg::command_line  cmd_q;   // command being issued

  // one command in flight between arbiter and issuer
  assign issuer_ready = (state == command_pkg::ISS_EMPTY) && !cmd_in.valid;
  assign cmd_req      = (state == command_pkg::ISS_REQ);

  always_comb begin
    cmd_out       = cmd_q;
    cmd_out.valid = (state != command_pkg::ISS_EMPTY);
  end

  ////////////////////////////////////////
  // four-phase handshake
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state <= command_pkg::ISS_EMPTY;
    end else begin
      case (state)
        command_pkg::ISS_EMPTY: begin
          if (cmd_in.valid) begin
            state <= command_pkg::ISS_REQ;  // req rises next cycle
          end
        end
        command_pkg::ISS_REQ: begin
          if (cmd_ack) begin
            state <= command_pkg::ISS_ACKED;
          end
        end
        command_pkg::ISS_ACKED: begin
          // wait for the host to release ack
          if (!cmd_ack) begin
            state <= command_pkg::ISS_EMPTY;
          end
        end
        default: state <= command_pkg::ISS_EMPTY;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if ((state == command_pkg::ISS_EMPTY) && cmd_in.valid) begin
      cmd_q <= cmd_in;
    end
  end

  // host samples cmd_out any time before ack
  cmd_out_stable: assert property (
    @(posedge clock) disable iff (!rstn)
      (cmd_req && !cmd_ack) |=> $stable(cmd_out)
  );

  // arbiter never sends a line while a command is held
  line_only_when_empty: assert property (
    @(posedge clock) disable iff (!rstn)
      cmd_in.valid |-> (state == command_pkg::ISS_EMPTY)
  );

endmodule

`default_nettype wire

/* verilog/command_subsys.sv */
`timescale 1ns/1ns
`default_nettype none

`include "command_defs.svh"

module command_subsys (
  input  logic                                  clock,
  input  logic                                  rstn,
  input  logic                                  enabled,
  input  logic [`NUM_CU-1:0]                    start,
  input  command_pkg::job_desc [`NUM_CU-1:0]    jobs,
  output logic [`NUM_CU-1:0]                    cu_busy,
  output logic                                  cmd_req,
  input  logic                                  cmd_ack,
  output command_pkg::command_line              cmd_out
);

  logic [`NUM_CU-1:0]                     gen_push;
  logic [`NUM_CU-1:0]                     fifo_full;
  logic [`NUM_CU-1:0]                     fifo_empty;
  logic [`NUM_CU-1:0]                     requests;
  logic [`NUM_CU-1:0]                     arb_ready;
  command_pkg::command_line [`NUM_CU-1:0] gen_cmd;
  command_pkg::command_line [`NUM_CU-1:0] fifo_head;
  command_pkg::command_line               arb_out;
  logic                                   issuer_ready;

  ////////////////////////////////////////
  // producers and their buffers
  ////////////////////////////////////////

  for (genvar i = 0; i < `NUM_CU; i++) begin : g_unit
    cu_command_gen #(
      .UNIT_ID (command_pkg::cu_id_t'(i))
    ) u_gen (
      .clock (clock),
      .rstn  (rstn),
      .start (start[i]),
      .job   (jobs[i]),
      .full  (fifo_full[i]),
      .push  (gen_push[i]),
      .cmd   (gen_cmd[i]),
      .busy  (cu_busy[i])
    );

    command_fifo #(
      .DEPTH (`CMD_FIFO_DEPTH)
    ) u_fifo (
      .clock     (clock),
      .rstn      (rstn),
      .push      (gen_push[i]),
      .push_data (gen_cmd[i]),
      .pop       (arb_ready[i]),
      .head      (fifo_head[i]),
      .full      (fifo_full[i]),
      .empty     (fifo_empty[i])
    );
  end

  assign requests = ~fifo_empty;  // request while anything is queued

  ////////////////////////////////////////
  // merge and issue
  ////////////////////////////////////////

  command_buffer_arbiter #(
    .NUM_REQUESTS (`NUM_CU)
  ) u_arbiter (
    .clock               (clock),
    .rstn                (rstn),
    .enabled             (enabled),
    .issuer_ready        (issuer_ready),
    .command_buffer_in   (fifo_head),
    .requests            (requests),
    .command_arbiter_out (arb_out),
    .ready               (arb_ready)
  );

  command_issuer u_issuer (
    .clock        (clock),
    .rstn         (rstn),
    .cmd_in       (arb_out),
    .issuer_ready (issuer_ready),
    .cmd_req      (cmd_req),
    .cmd_ack      (cmd_ack),
    .cmd_out      (cmd_out)
  );

endmodule

`default_nettype wire

/* sim/command_subsys_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "command_defs.svh"

module command_subsys_tb;

  localparam int WAIT_LIMIT   = 200;   // cycles for short waits
  localparam int DRAIN_LIMIT  = 6000;  // cycles for a whole phase
  localparam int QUIET_CYCLES = 20;    // idle cycles that mean drained

  logic                               clock;
  logic                               rstn;
  logic                               enabled;
  logic [`NUM_CU-1:0]                 start;
  command_pkg::job_desc [`NUM_CU-1:0] jobs;
  command_pkg::job_desc [`NUM_CU-1:0] next_jobs;
  logic [`NUM_CU-1:0]                 cu_busy;
  logic                               cmd_req;
  logic                               cmd_ack = 1'b0;
  command_pkg::command_line           cmd_out;

  // host model
  int   seed = 46566;
  int   ack_min;
  int   ack_max;
  int   ack_count;
  int   ack_delay;
  int   rand_word;
  logic ack_armed;

  // scoreboard
  command_pkg::command_line exp_q [`NUM_CU][$];  // expected lines per unit
  int                       pending_q [`NUM_CU];
  logic                     req_seen;
  logic                     cmp_valid;
  logic                     exp_present;
  command_pkg::command_line got_line;
  command_pkg::command_line exp_line;
  command_pkg::cu_id_t      last_cu;
  command_pkg::cu_id_t      order_prev;
  logic                     prio_check;

  int content_errors  = 0;
  int order_errors    = 0;
  int protocol_errors = 0;

  command_subsys DUT (
    .clock   (clock),
    .rstn    (rstn),
    .enabled (enabled),
    .start   (start),
    .jobs    (jobs),
    .cu_busy (cu_busy),
    .cmd_req (cmd_req),
    .cmd_ack (cmd_ack),
    .cmd_out (cmd_out)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  ////////////////////////////////////////
  // host side of the four-phase handshake
  ////////////////////////////////////////

  always @(posedge clock) begin
    if (!rstn) begin
      cmd_ack   <= 1'b0;
      ack_armed <= 1'b0;
      ack_count <= 0;
    end else if (cmd_ack) begin
      if (!cmd_req) begin
        cmd_ack <= 1'b0;  // release after req drops
      end
    end else if (cmd_req) begin
      if (!ack_armed) begin
        rand_word = $random(seed);
        ack_delay = ack_min + ((rand_word & 32'h7fff_ffff) % (ack_max - ack_min + 1));
        if (ack_delay == 0) begin
          cmd_ack <= 1'b1;
        end else begin
          ack_armed <= 1'b1;
          ack_count <= ack_delay;
        end
      end else if (ack_count <= 1) begin
        cmd_ack   <= 1'b1;
        ack_armed <= 1'b0;
      end else begin
        ack_count <= ack_count - 1;
      end
    end
  end

  ////////////////////////////////////////
  // expected commands
  ////////////////////////////////////////

  // cut a job into cacheline lines, last one takes the rest
  function automatic void queue_job(input int unit, input command_pkg::job_desc job);
    command_pkg::command_line line;
    command_pkg::address_t    addr;
    int                       remain;
    remain = int'(job.length);
    addr   = job.base;
    while (remain > 0) begin
      line.valid   = 1'b1;
      line.cu_id   = command_pkg::cu_id_t'(unit);
      line.op      = job.op;
      line.address = addr;
      line.size    = command_pkg::xfer_size_t'((remain > `CACHELINE_BYTES) ?
                                               `CACHELINE_BYTES : remain);
      exp_q[unit].push_back(line);
      addr   = addr + command_pkg::address_t'(`CACHELINE_BYTES);
      remain = remain - `CACHELINE_BYTES;
    end
  endfunction

  always @(posedge clock) begin
    if (!rstn) begin
      req_seen  <= 1'b0;
      cmp_valid <= 1'b0;
      last_cu   <= '0;
    end else begin
      req_seen  <= cmd_req;
      cmp_valid <= 1'b0;
      for (int i = 0; i < `NUM_CU; i++) begin
        if (start[i]) begin
          queue_job(i, jobs[i]);
        end
      end
      if (cmd_req && !req_seen) begin  // req rising
        cmp_valid   <= 1'b1;
        got_line    <= cmd_out;
        order_prev  <= last_cu;
        last_cu     <= cmd_out.cu_id;
        exp_present <= (exp_q[cmd_out.cu_id].size() > 0);
        if (exp_q[cmd_out.cu_id].size() > 0) begin
          exp_line <= exp_q[cmd_out.cu_id].pop_front();
        end
      end else if (!prio_check) begin
        last_cu <= '0;
      end
      for (int i = 0; i < `NUM_CU; i++) begin
        pending_q[i] <= exp_q[i].size();
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  content_check: assert property (@(posedge clock) disable iff (!rstn)
    (cmp_valid && exp_present) |-> (got_line.valid == exp_line.valid &&
      got_line.address == exp_line.address && got_line.size == exp_line.size &&
      got_line.op == exp_line.op))
    else begin
      content_errors++;
      $display("error: cmd_out valid %h address %h size %h op %h, expected %h %h %h %h",
        $sampled(got_line.valid), $sampled(got_line.address), $sampled(got_line.size),
        $sampled(got_line.op), $sampled(exp_line.valid), $sampled(exp_line.address),
        $sampled(exp_line.size), $sampled(exp_line.op));
    end

  expected_check: assert property (@(posedge clock) disable iff (!rstn)
    cmp_valid |-> exp_present)
    else begin
      order_errors++;
      $display("unit %0d issued a command that was never expected", $sampled(got_line.cu_id));
    end

  priority_check: assert property (@(posedge clock) disable iff (!rstn)
    (cmp_valid && prio_check) |-> (got_line.cu_id >= order_prev))
    else begin
      order_errors++;
      $display("error: cmd_out.cu_id %h issued after cu_id %h",
        $sampled(got_line.cu_id), $sampled(order_prev));
    end

  req_fall_after_ack: assert property (@(posedge clock) disable iff (!rstn)
    $fell(cmd_req) |-> $past(cmd_ack))
    else begin
      protocol_errors++;
      $display("cmd_req dropped before the host raised cmd_ack");
    end

  req_rise_ack_low: assert property (@(posedge clock) disable iff (!rstn)
    $rose(cmd_req) |-> !cmd_ack)
    else begin
      protocol_errors++;
      $display("cmd_req rose while cmd_ack was still high");
    end

  cmd_held: assert property (@(posedge clock) disable iff (!rstn)
    (cmd_req && $past(cmd_req)) |-> $stable(cmd_out))
    else begin
      protocol_errors++;
      $display("cmd_out changed while cmd_req was high");
    end

  idle_after_reset: assert property (@(posedge clock)
    $rose(rstn) |-> (!cmd_req && cu_busy == '0))
    else begin
      protocol_errors++;
      $display("cmd_req or cu_busy high right after reset");
    end

  // a grant two cycles back is the only way to start a request
  gated_by_enable: assert property (@(posedge clock) disable iff (!rstn)
    $rose(cmd_req) |-> $past(enabled, 2))
    else begin
      protocol_errors++;
      $display("cmd_req rose although enabled was low");
    end

  for (genvar u = 0; u < `NUM_CU; u++) begin : g_busy
    // fifo plus one line in flight may still be waiting
    busy_until_queued: assert property (@(posedge clock) disable iff (!rstn)
      $fell(cu_busy[u]) |-> (pending_q[u] <= `CMD_FIFO_DEPTH + 1))
      else begin
        order_errors++;
        $display("unit %0d dropped cu_busy before its last command was queued", u);
      end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  function automatic command_pkg::job_desc make_job(input command_pkg::address_t base,
                                                    input int length,
                                                    input command_pkg::cmd_op_t op);
    command_pkg::job_desc job;
    job.base   = base;
    job.length = command_pkg::job_len_t'(length);
    job.op     = op;
    return job;
  endfunction

  task automatic report_counts();
    $display("errors: content %0d, order %0d, protocol %0d",
      content_errors, order_errors, protocol_errors);
  endtask

  task automatic abort_run(input string what);
    $display("timeout while waiting for %s", what);
    report_counts();
    $display("Simulation failed");
    $finish;
  endtask

  task automatic start_jobs(input logic [`NUM_CU-1:0] mask);
    @(posedge clock);
    jobs  <= next_jobs;
    start <= mask;
    @(posedge clock);
    start <= '0;
  endtask

  task automatic wait_all_busy(input string what);
    int cycles;
    cycles = 0;
    while (cu_busy != {`NUM_CU{1'b1}}) begin
      @(posedge clock);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run(what);
    end
  endtask

  task automatic wait_req(input string what);
    int cycles;
    cycles = 0;
    while (!cmd_req) begin
      @(posedge clock);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run(what);
    end
  endtask

  // no busy unit and no handshake for a while
  task automatic wait_drained(input string what);
    int cycles;
    int quiet;
    cycles = 0;
    quiet  = 0;
    while (quiet < QUIET_CYCLES) begin
      @(posedge clock);
      cycles++;
      if (cu_busy == '0 && !cmd_req && !cmd_ack) quiet++;
      else quiet = 0;
      if (cycles > DRAIN_LIMIT) abort_run(what);
    end
  endtask

  task automatic check_drained(input string what);
    @(negedge clock);
    for (int u = 0; u < `NUM_CU; u++) begin
      assert (exp_q[u].size() == 0) else begin
        order_errors++;
        $display("unit %0d is missing %0d commands after %s", u, exp_q[u].size(), what);
      end
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    rstn       = 1'b0;
    enabled    = 1'b0;
    start      = '0;
    jobs       = '0;
    next_jobs  = '0;
    ack_min    = 0;
    ack_max    = 3;
    prio_check = 1'b0;
    repeat (10) @(posedge clock);
    rstn    <= 1'b1;
    @(posedge clock);
    enabled <= 1'b1;

    // odd tail, zero length, unaligned base
    next_jobs[0] = make_job(64'h1000, 300, `CMD_OP_READ);
    next_jobs[1] = make_job(64'h8000, 0, `CMD_OP_WRITE);
    next_jobs[2] = make_job(64'h0000_2000_0000_0040, 512, `CMD_OP_WRITE);
    next_jobs[3] = make_job(64'h4_0000, 100, `CMD_OP_WRITE);
    start_jobs(4'b1111);
    wait_drained("mixed jobs to drain");
    check_drained("mixed jobs");

    // all units loaded while the arbiter is held off
    @(posedge clock);
    enabled    <= 1'b0;
    prio_check <= 1'b1;
    next_jobs[0] = make_job(64'h10_0000, 1024, `CMD_OP_READ);
    next_jobs[1] = make_job(64'h20_0000, 1100, `CMD_OP_WRITE);
    next_jobs[2] = make_job(64'h30_0000, 1280, `CMD_OP_READ);
    next_jobs[3] = make_job(64'h40_0000, 1030, `CMD_OP_WRITE);
    start_jobs(4'b1111);
    wait_all_busy("all units busy");
    repeat (5) @(posedge clock);
    enabled <= 1'b1;
    wait_drained("priority jobs to drain");
    check_drained("priority jobs");
    @(posedge clock);
    prio_check <= 1'b0;

    // pause the arbiter in the middle of traffic
    next_jobs[0] = make_job(64'h50_0000, 700, `CMD_OP_WRITE);
    next_jobs[1] = make_job(64'h60_0010, 650, `CMD_OP_READ);
    next_jobs[2] = make_job(64'h70_0000, 900, `CMD_OP_WRITE);
    next_jobs[3] = make_job(64'h80_0000, 500, `CMD_OP_READ);
    start_jobs(4'b1111);
    wait_req("first request after start");
    enabled <= 1'b0;
    repeat (60) @(posedge clock);
    enabled <= 1'b1;
    wait_drained("paused jobs to drain");
    check_drained("paused jobs");

    // slow host, fifos fill and stall the generators
    @(posedge clock);
    ack_min <= 20;
    ack_max <= 20;
    next_jobs[0] = make_job(64'h90_0000, 1200, `CMD_OP_READ);
    next_jobs[1] = make_job(64'ha0_0000, 1300, `CMD_OP_WRITE);
    next_jobs[2] = make_job(64'hb0_0020, 1100, `CMD_OP_READ);
    next_jobs[3] = make_job(64'hc0_0000, 1500, `CMD_OP_WRITE);
    start_jobs(4'b1111);
    wait_drained("slow host jobs to drain");
    check_drained("slow host jobs");

    report_counts();
    if (content_errors + order_errors + protocol_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* command_subsys.f */
+incdir+include
verilog/command_pkg.sv
verilog/cu_command_gen.sv
verilog/command_fifo.sv
verilog/command_buffer_arbiter.sv
verilog/command_issuer.sv
verilog/command_subsys.sv
sim/command_subsys_tb.sv

/* Makefile */
# Verilator build and run for the command path testbench

VERILATOR ?= verilator
TOP       ?= command_subsys_tb
FILELIST  ?= command_subsys.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || \
	   ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
